//--- Makefile
# Verilator build and run of the 6502 front end testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu6502
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
source/cpu6502_pkg.sv
source/ctrl_if.sv
source/decode_rom.sv
source/instr_sequencer.sv
source/datapath.sv
source/cpu6502_top.sv
test/tb_cpu6502.sv

//--- source/cpu6502_pkg.sv
// shared definitions for the 6502 front end
// opcodes, timing count width, reset values
// and the program counter word/byte union

package cpu6502_pkg;

    // opcodes handled by the decode ROM
    localparam logic [7:0] OPCODE_BRK     = 8'h00;
    localparam logic [7:0] OPCODE_NOP     = 8'hea;
    localparam logic [7:0] OPCODE_LDA_IMM = 8'ha9;
    localparam logic [7:0] OPCODE_JMP_ABS = 8'h4c;

    // timing count covers T0..T6 of the vector sequence
    localparam int TCU_W = 3;

    localparam logic [7:0]  S_RESET        = 8'h00;
    localparam logic [15:0] PC_RESET       = 16'h0000;
    localparam logic [15:0] VECTOR_ADDR_LO = 16'hfffc;

    // PC seen as one word for increment, or as two bytes for loads
    typedef struct packed {
        logic [7:0] pch;
        logic [7:0] pcl;
    } pc_bytes_t;

    typedef union packed {
        logic [15:0] word;
        pc_bytes_t   half;
    } pc_word_u;

endpackage

//--- source/cpu6502_top.sv
// 6502 front end top level
// sequencer, decode ROM and datapath joined by the control bundle

`timescale 1ns/1ps

module cpu6502_top
    import cpu6502_pkg::*;
(
    input  logic        i_phi2,
    input  logic        i_rst_n,
    input  logic [7:0]  i_data,
    output logic [15:0] o_addr,
    output logic        o_rw,
    output logic        o_sync,
    output logic [7:0]  o_ac
);

    logic [7:0]       ir;
    logic [TCU_W-1:0] tcu;
    logic [TCU_W-1:0] tcu_next;
    logic             interrupt;
    logic             ir_load;

    ctrl_if ctrl ();

    instr_sequencer u_seq (
        .i_phi2      (i_phi2),
        .i_rst_n     (i_rst_n),
        .i_data      (i_data),
        .i_tcu_next  (tcu_next),
        .i_ir_load   (ir_load),
        .o_ir        (ir),
        .o_tcu       (tcu),
        .o_interrupt (interrupt),
        .o_sync      (o_sync)
    );

    decode_rom u_rom (
        .i_ir        (ir),
        .i_tcu       (tcu),
        .i_interrupt (interrupt),
        .o_ctrl      (ctrl.decoder),
        .o_tcu       (tcu_next),
        .o_ir_load   (ir_load)
    );

    datapath u_dp (
        .i_phi2  (i_phi2),
        .i_rst_n (i_rst_n),
        .i_data  (i_data),
        .i_ctrl  (ctrl.datapath),
        .o_addr  (o_addr),
        .o_ac    (o_ac)
    );

    // no write cycles in this core
    assign o_rw = 1'b1;

endmodule

//--- source/ctrl_if.sv
// control lines from the decode ROM to the datapath
// decoder side drives, datapath side receives

`timescale 1ns/1ps

interface ctrl_if;

    // address bus sources
    logic pcl_adl;
    logic pch_adh;
    logic s_adl;
    logic zero_adl0;
    logic zero_adl1;
    logic zero_adh1_7;
    logic adl_abl;
    logic adh_abh;

    // program counter and stack pointer
    logic i_pc;
    logic adl_pcl;
    logic data_pch;
    logic s_dec;

    // register moves
    logic dl_db;
    logic db_sb;
    logic sb_ac;
    logic dl_adl;

    modport decoder (
        output pcl_adl, pch_adh, s_adl, zero_adl0, zero_adl1, zero_adh1_7,
        output adl_abl, adh_abh, i_pc, adl_pcl, data_pch, s_dec,
        output dl_db, db_sb, sb_ac, dl_adl
    );

    modport datapath (
        input pcl_adl, pch_adh, s_adl, zero_adl0, zero_adl1, zero_adh1_7,
        input adl_abl, adh_abh, i_pc, adl_pcl, data_pch, s_dec,
        input dl_db, db_sb, sb_ac, dl_adl
    );

endinterface

//--- source/datapath.sv
// datapath
// internal ADL, ADH, DB and SB buses with precharge,
// address bus register, PC, stack pointer, data latch and AC

`timescale 1ns/1ps

module datapath
    import cpu6502_pkg::*;
(
    input  logic        i_phi2,
    input  logic        i_rst_n,
    input  logic [7:0]  i_data,
    ctrl_if.datapath    i_ctrl,
    output logic [15:0] o_addr,
    output logic [7:0]  o_ac
);

    pc_word_u    pc;
    pc_word_u    pc_inc;
    logic [7:0]  pcl_in;
    logic [7:0]  pch_in;
    logic [7:0]  s;
    logic [7:0]  s_next;
    logic [7:0]  dl;
    logic [7:0]  ac;
    logic [7:0]  adl;
    logic [7:0]  adh;
    logic [7:0]  db;
    logic [7:0]  sb;
    logic [15:0] abus;

    // incrementer works on the whole word
    always_comb
    begin
        pc_inc.word = i_ctrl.i_pc ? pc.word + 16'd1 : pc.word;
        s_next      = i_ctrl.s_dec ? s - 8'd1 : s;
    end

    // buses float high, every source pulls bits low
    always_comb
    begin
        adl = 8'hff;
        if (i_ctrl.pcl_adl)
        begin
            adl = adl & pc_inc.half.pcl;
        end
        if (i_ctrl.s_adl)
        begin
            adl = adl & s_next;
        end
        if (i_ctrl.dl_adl)
        begin
            adl = adl & dl;
        end
        if (i_ctrl.zero_adl0)
        begin
            adl[0] = 1'b0;
        end
        if (i_ctrl.zero_adl1)
        begin
            adl[1] = 1'b0;
        end

        adh = 8'hff;
        if (i_ctrl.pch_adh)
        begin
            adh = adh & pch_in;
        end
        if (i_ctrl.zero_adh1_7)
        begin
            adh[7:1] = 7'd0;
        end

        // DB side of the latch passes the live read through
        db = i_ctrl.dl_db ? i_data : 8'hff;
        sb = i_ctrl.db_sb ? db : 8'hff;
    end

    // separate byte loads, PCH from the data pins
    assign pcl_in = i_ctrl.adl_pcl ? adl : pc_inc.half.pcl;
    assign pch_in = i_ctrl.data_pch ? i_data : pc_inc.half.pch;

    always_ff @(posedge i_phi2 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            abus    <= PC_RESET;
            pc.word <= PC_RESET;
            s       <= S_RESET;
            ac      <= 8'h00;
        end
        else
        begin
            if (i_ctrl.adl_abl)
            begin
                abus[7:0] <= adl;
            end
            if (i_ctrl.adh_abh)
            begin
                abus[15:8] <= adh;
            end
            pc.half.pcl <= pcl_in;
            pc.half.pch <= pch_in;
            s           <= s_next;
            if (i_ctrl.sb_ac)
            begin
                ac <= sb;
            end
        end
    end

    // data latch catches every read
    always_ff @(posedge i_phi2)
    begin
        dl <= i_data;
    end

    assign o_addr = abus;
    assign o_ac   = ac;

endmodule

//--- source/decode_rom.sv
// decode ROM, combinational
// maps IR and TCU to the datapath control lines and the next TCU

`timescale 1ns/1ps

module decode_rom
    import cpu6502_pkg::*;
(
    input  logic [7:0]       i_ir,
    input  logic [TCU_W-1:0] i_tcu,
    input  logic             i_interrupt,
    ctrl_if.decoder          o_ctrl,
    output logic [TCU_W-1:0] o_tcu,
    output logic             o_ir_load
);

    logic [7:0] op;

    // opcodes outside the supported set run as NOP
    always_comb
    begin
        case (i_ir)
            OPCODE_BRK, OPCODE_LDA_IMM, OPCODE_JMP_ABS:
                op = i_ir;
            default:
                op = OPCODE_NOP;
        endcase
    end

    // sources chosen in a step land in the address register,
    // so each step sets up the address of the following step
    always_comb
    begin
        o_tcu     = i_tcu + TCU_W'(1);
        o_ir_load = 1'b0;

        o_ctrl.pcl_adl     = 1'b0;
        o_ctrl.pch_adh     = 1'b0;
        o_ctrl.s_adl       = 1'b0;
        o_ctrl.zero_adl0   = 1'b0;
        o_ctrl.zero_adl1   = 1'b0;
        o_ctrl.zero_adh1_7 = 1'b0;
        o_ctrl.adl_abl     = 1'b0;
        o_ctrl.adh_abh     = 1'b0;
        o_ctrl.i_pc        = 1'b0;
        o_ctrl.adl_pcl     = 1'b0;
        o_ctrl.data_pch    = 1'b0;
        o_ctrl.s_dec       = 1'b0;
        o_ctrl.dl_db       = 1'b0;
        o_ctrl.db_sb       = 1'b0;
        o_ctrl.sb_ac       = 1'b0;
        o_ctrl.dl_adl      = 1'b0;

        case (i_tcu)
            TCU_W'(0):
            begin
                // opcode fetch, same for every instruction
                o_ctrl.i_pc    = 1'b1;
                o_ctrl.pcl_adl = 1'b1;
                o_ctrl.pch_adh = 1'b1;
                o_ctrl.adl_abl = 1'b1;
                o_ctrl.adh_abh = 1'b1;
                o_ir_load      = !i_interrupt;
            end
            TCU_W'(1):
            begin
                o_ctrl.adl_abl = 1'b1;
                o_ctrl.adh_abh = 1'b1;
                case (op)
                    OPCODE_BRK:
                    begin
                        // first stack page address, 01:S
                        o_ctrl.s_adl       = 1'b1;
                        o_ctrl.zero_adh1_7 = 1'b1;
                    end
                    OPCODE_LDA_IMM:
                    begin
                        // operand straight into AC
                        o_ctrl.dl_db   = 1'b1;
                        o_ctrl.db_sb   = 1'b1;
                        o_ctrl.sb_ac   = 1'b1;
                        o_ctrl.i_pc    = 1'b1;
                        o_ctrl.pcl_adl = 1'b1;
                        o_ctrl.pch_adh = 1'b1;
                        o_tcu          = '0;
                    end
                    OPCODE_JMP_ABS:
                    begin
                        // low byte caught by DL, step to high byte
                        o_ctrl.i_pc    = 1'b1;
                        o_ctrl.pcl_adl = 1'b1;
                        o_ctrl.pch_adh = 1'b1;
                    end
                    default:
                    begin
                        // NOP refetches at the current PC
                        o_ctrl.pcl_adl = 1'b1;
                        o_ctrl.pch_adh = 1'b1;
                        o_tcu          = '0;
                    end
                endcase
            end
            TCU_W'(2), TCU_W'(3):
            begin
                if (op == OPCODE_BRK)
                begin
                    o_ctrl.s_adl       = 1'b1;
                    o_ctrl.s_dec       = 1'b1;
                    o_ctrl.zero_adh1_7 = 1'b1;
                    o_ctrl.adl_abl     = 1'b1;
                    o_ctrl.adh_abh     = 1'b1;
                end
                else
                begin
                    // JMP high byte, PC loads {data, DL}
                    o_ctrl.dl_adl   = 1'b1;
                    o_ctrl.adl_pcl  = 1'b1;
                    o_ctrl.data_pch = 1'b1;
                    o_ctrl.pch_adh  = 1'b1;
                    o_ctrl.adl_abl  = 1'b1;
                    o_ctrl.adh_abh  = 1'b1;
                    o_tcu           = '0;
                end
            end
            TCU_W'(4):
            begin
                // vector low address FFFC, ADH left precharged
                o_ctrl.s_dec     = 1'b1;
                o_ctrl.zero_adl0 = 1'b1;
                o_ctrl.zero_adl1 = 1'b1;
                o_ctrl.adl_abl   = 1'b1;
                o_ctrl.adh_abh   = 1'b1;
            end
            TCU_W'(5):
            begin
                // vector high address FFFD
                o_ctrl.zero_adl1 = 1'b1;
                o_ctrl.adl_abl   = 1'b1;
                o_ctrl.adh_abh   = 1'b1;
            end
            TCU_W'(6):
            begin
                o_ctrl.dl_adl   = 1'b1;
                o_ctrl.adl_pcl  = 1'b1;
                o_ctrl.data_pch = 1'b1;
                o_ctrl.pch_adh  = 1'b1;
                o_ctrl.adl_abl  = 1'b1;
                o_ctrl.adh_abh  = 1'b1;
                o_tcu           = '0;
            end
            default:
            begin
                // unused step, back to fetch
                o_tcu = '0;
            end
        endcase
    end

endmodule

//--- source/instr_sequencer.sv
// instruction sequencer
// IR, timing count and interrupt pending registers,
// reset forces BRK into the IR

`timescale 1ns/1ps

module instr_sequencer
    import cpu6502_pkg::*;
(
    input  logic             i_phi2,
    input  logic             i_rst_n,
    input  logic [7:0]       i_data,
    input  logic [TCU_W-1:0] i_tcu_next,
    input  logic             i_ir_load,
    output logic [7:0]       o_ir,
    output logic [TCU_W-1:0] o_tcu,
    output logic             o_interrupt,
    output logic             o_sync
);

    logic [7:0]       ir;
    logic [TCU_W-1:0] tcu;
    logic             pending;
    logic             sync;

    always_ff @(posedge i_phi2 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            ir      <= OPCODE_BRK;
            tcu     <= '0;
            pending <= 1'b1;
            sync    <= 1'b0;
        end
        else
        begin
            tcu  <= i_tcu_next;
            // high in T1 of a fetched instruction
            sync <= i_ir_load;
            if (i_ir_load)
            begin
                ir <= i_data;
            end
            // forced sequence done once the count wraps to T0
            if (pending && (i_tcu_next == '0))
            begin
                pending <= 1'b0;
            end
        end
    end

    assign o_ir        = ir;
    assign o_tcu       = tcu;
    assign o_interrupt = pending;
    assign o_sync      = sync;

endmodule

//--- test/tb_cpu6502.sv
// testbench for the 6502 front end
// memory model, cycle trace reference model, directed tests,
// random program test, watchdog and summary

`timescale 1ns/1ps

module tb_cpu6502
    import cpu6502_pkg::*;
();

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 16;
    localparam int VECTOR_CYCLES = 7;
    localparam int RANDOM_INSTRS = 40;
    localparam int MAX_INSTR_CYC = 3;
    // five directed tests of at most two vector runs and four instructions each
    localparam int DIRECTED_CYC  = 5 * (RESET_CYCLES + 2 * VECTOR_CYCLES + 4 * MAX_INSTR_CYC + 2);
    localparam int RANDOM_CYC    = RESET_CYCLES + VECTOR_CYCLES + RANDOM_INSTRS * MAX_INSTR_CYC + 2;
    localparam int WATCHDOG_CYC  = 2 * (DIRECTED_CYC + RANDOM_CYC) + 100;

    logic        phi2 = 1'b0;
    logic        rst_n = 1'b0;
    logic [7:0]  data;
    logic [15:0] addr;
    logic        rw;
    logic        sync;
    logic [7:0]  ac;

    logic [7:0]  mem [0:65535];
    logic [31:0] rng_state = 32'd45963;

    // reference model state and expected per-cycle trace
    pc_word_u    m_pc;
    logic [7:0]  m_s;
    logic [7:0]  m_ac;
    logic [15:0] exp_addr [$];
    logic        exp_sync [$];

    int test_errors  = 0;
    int total_errors = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    cpu6502_top cpu6502_i (
        .i_phi2  (phi2),
        .i_rst_n (rst_n),
        .i_data  (data),
        .o_addr  (addr),
        .o_rw    (rw),
        .o_sync  (sync),
        .o_ac    (ac)
    );

    // read data for the current address in the same cycle
    assign data = mem[addr];

    always #(CLK_PERIOD / 2) phi2 = ~phi2;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic fill_memory(input logic [15:0] vector);
        int a;
        for (a = 0; a < 65536; a++)
        begin
            mem[a[15:0]] = a[7:0] ^ {a[14:8], a[15]} ^ 8'h96;
        end
        mem[VECTOR_ADDR_LO] = vector[7:0];
        mem[VECTOR_ADDR_LO + 16'd1] = vector[15:8];
    endtask

    task automatic push_cycle(input logic [15:0] a, input logic s);
        exp_addr.push_back(a);
        exp_sync.push_back(s);
    endtask

    // three stack reads then the vector reads of reset or BRK
    task automatic model_vector_tail();
        int k;
        for (k = 0; k < 3; k++)
        begin
            push_cycle({8'h01, m_s}, 1'b0);
            m_s = m_s - 8'd1;
        end
        push_cycle(VECTOR_ADDR_LO, 1'b0);
        push_cycle(VECTOR_ADDR_LO + 16'd1, 1'b0);
        m_pc.half.pcl = mem[VECTOR_ADDR_LO];
        m_pc.half.pch = mem[VECTOR_ADDR_LO + 16'd1];
    endtask

    task automatic model_reset();
        exp_addr.delete();
        exp_sync.delete();
        m_pc.word = PC_RESET;
        m_s = S_RESET;
        m_ac = 8'h00;
        push_cycle(m_pc.word, 1'b0);
        m_pc.word = m_pc.word + 16'd1;
        // no sync while the forced BRK runs
        push_cycle(m_pc.word, 1'b0);
        model_vector_tail();
    endtask

    task automatic model_instr();
        logic [7:0] op;
        logic [7:0] lo;
        op = mem[m_pc.word];
        push_cycle(m_pc.word, 1'b0);
        m_pc.word = m_pc.word + 16'd1;
        push_cycle(m_pc.word, 1'b1);
        case (op)
            OPCODE_BRK:
            begin
                model_vector_tail();
            end
            OPCODE_LDA_IMM:
            begin
                m_ac = mem[m_pc.word];
                m_pc.word = m_pc.word + 16'd1;
            end
            OPCODE_JMP_ABS:
            begin
                lo = mem[m_pc.word];
                m_pc.word = m_pc.word + 16'd1;
                push_cycle(m_pc.word, 1'b0);
                m_pc.half.pch = mem[m_pc.word];
                m_pc.half.pcl = lo;
            end
            default:
            begin
                // PC already points at the next fetch for NOP and undefined opcodes
            end
        endcase
    endtask

    task automatic pulse_reset();
        @(posedge phi2);
        #1;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge phi2);
        #1;
        rst_n = 1'b1;
    endtask

    // reset the DUT, then compare every cycle against the expected trace
    task automatic run_trace(input string name);
        int i;
        pulse_reset();
        for (i = 0; i < exp_addr.size(); i++)
        begin
            @(negedge phi2);
            assert (addr == exp_addr[i])
            else
            begin
                $display("Mismatch in %s: cycle %0d o_addr expected %h, actual %h",
                         name, i, exp_addr[i], addr);
                test_errors++;
            end
            assert (sync == exp_sync[i])
            else
            begin
                $display("Mismatch in %s: cycle %0d o_sync expected %b, actual %b",
                         name, i, exp_sync[i], sync);
                test_errors++;
            end
            assert (rw == 1'b1)
            else
            begin
                $display("Mismatch in %s: cycle %0d o_rw expected 1, actual %b", name, i, rw);
                test_errors++;
            end
        end
    endtask

    task automatic check_ac(input string name, input logic [7:0] expected);
        assert (ac == expected)
        else
        begin
            $display("Mismatch in %s: o_ac expected %h, actual %h", name, expected, ac);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0)
        begin
            $display("%s: ok, %0d cycles", name, exp_addr.size());
        end
        else
        begin
            $display("%s: %0d errors", name, test_errors);
            tests_failed++;
            total_errors += test_errors;
        end
        test_errors = 0;
    endtask

    task automatic test_reset_trace();
        logic [15:0] trace [7];
        int i;
        trace = '{16'h0000, 16'h0001, 16'h0100, 16'h01ff, 16'h01fe, 16'hfffc, 16'hfffd};
        fill_memory(16'h0300);
        exp_addr.delete();
        exp_sync.delete();
        for (i = 0; i < 7; i++)
        begin
            push_cycle(trace[i], 1'b0);
        end
        run_trace("reset_trace");
        finish_test("reset_trace");
    endtask

    task automatic test_vector_fetch();
        fill_memory(16'h1234);
        mem[16'h1234] = OPCODE_NOP;
        model_reset();
        model_instr();
        run_trace("vector_fetch");
        finish_test("vector_fetch");
    endtask

    task automatic test_nop();
        fill_memory(16'h0400);
        mem[16'h0400] = OPCODE_NOP;
        // undefined opcode runs as NOP
        mem[16'h0401] = 8'hff;
        model_reset();
        model_instr();
        model_instr();
        push_cycle(m_pc.word, 1'b0);
        run_trace("nop");
        finish_test("nop");
    endtask

    task automatic test_lda_imm();
        fill_memory(16'h0500);
        mem[16'h0500] = OPCODE_LDA_IMM;
        mem[16'h0501] = 8'h5a;
        model_reset();
        model_instr();
        push_cycle(m_pc.word, 1'b0);
        run_trace("lda_imm");
        check_ac("lda_imm", 8'h5a);
        finish_test("lda_imm");
    endtask

    task automatic test_jmp_brk();
        fill_memory(16'h0600);
        mem[16'h0600] = OPCODE_JMP_ABS;
        mem[16'h0601] = 8'h00;
        mem[16'h0602] = 8'h80;
        mem[16'h8000] = OPCODE_BRK;
        model_reset();
        model_instr();
        model_instr();
        push_cycle(m_pc.word, 1'b0);
        run_trace("jmp_brk");
        finish_test("jmp_brk");
    endtask

    // code runs within pages and every JMP lands on a page not used before
    task automatic test_random_program();
        bit          page_used [256];
        logic [15:0] cur;
        logic [15:0] target;
        logic [31:0] r;
        logic [31:0] pick;
        logic [7:0]  page;
        int          i;
        int          k;
        fill_memory(16'h0200);
        for (k = 0; k < 256; k++)
        begin
            page_used[k] = 1'b0;
        end
        page_used[8'h00] = 1'b1;
        page_used[8'h01] = 1'b1;
        page_used[8'h02] = 1'b1;
        page_used[8'hff] = 1'b1;
        cur = 16'h0200;
        for (i = 0; i < RANDOM_INSTRS; i++)
        begin
            r = next_random();
            case (r % 32'd3)
                32'd0:
                begin
                    mem[cur] = OPCODE_NOP;
                    cur = cur + 16'd1;
                end
                32'd1:
                begin
                    mem[cur] = OPCODE_LDA_IMM;
                    mem[cur + 16'd1] = r[23:16];
                    cur = cur + 16'd2;
                end
                default:
                begin
                    pick = next_random();
                    page = pick[15:8];
                    for (k = 0; k < 256; k++)
                    begin
                        if (!page_used[page])
                        begin
                            break;
                        end
                        page = page + 8'd1;
                    end
                    page_used[page] = 1'b1;
                    target = {page, 1'b0, r[22:16]};
                    mem[cur] = OPCODE_JMP_ABS;
                    mem[cur + 16'd1] = target[7:0];
                    mem[cur + 16'd2] = target[15:8];
                    cur = target;
                end
            endcase
        end
        mem[cur] = OPCODE_NOP;
        model_reset();
        for (i = 0; i < RANDOM_INSTRS; i++)
        begin
            model_instr();
        end
        push_cycle(m_pc.word, 1'b0);
        run_trace("random_program");
        check_ac("random_program", m_ac);
        finish_test("random_program");
    endtask

    initial
    begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Error: watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        fill_memory(16'h0000);
        test_reset_trace();
        test_vector_fetch();
        test_nop();
        test_lda_imm();
        test_jmp_brk();
        test_random_program();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (tests_failed == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
